// ==== build.f ====
source/blaster_pkg.sv
source/key_scan.sv
source/tone_gen.sv
source/hv_control.sv
source/blaster_top.sv
verification/blaster_tb.sv

// ==== Makefile ====
# Verilator build and run of the blaster testbench

VERILATOR ?= verilator
TOP       ?= blaster_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/blaster_tb.sv ====
`timescale 1ns/10ps

module blaster_tb;

	localparam int SCAN_BITS       = 12;
	localparam int TRIGGER_BITS    = 10;
	localparam int MIN_ON          = 48;
	localparam int MAX_ON          = 768;
	localparam int MIN_OFF         = 144;
	localparam int I_HIGH          = 430;
	localparam int I_LOW           = 390;
	localparam int PULSES_PER_SHOT = 3;
	localparam int SCAN_CYCLES     = 1 << SCAN_BITS;
	localparam int TICK_CYCLES     = 1 << TRIGGER_BITS;
	localparam int TIMEOUT_CYCLES  = 300000;
	localparam int SEL_PWM         = 0;
	localparam int SEL_DUMP        = 1;
	localparam int SEL_CHARGE      = 2;
	localparam int SEL_SPEAKER     = 3;

	logic        clk = 1'b0;
	logic        reset;
	logic        fire_button;
	logic        lt3420_done;
	logic        cont_n;
	logic [11:0] current_sample;
	logic [6:0]  keypad_in = 7'h7F;
	logic [6:0]  keypad_out;
	logic        speaker;
	logic        speaker_n;
	logic        pwm;
	logic        dump;
	logic        lt3420_charge;
	logic        arm_led_n;
	logic        cont_led_n;
	logic        key_held = 1'b0;
	int          held_row = 0;
	int          held_col = 0;
	int          error_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;

	blaster_top #(
		.SCAN_BITS       (SCAN_BITS),
		.TRIGGER_BITS    (TRIGGER_BITS),
		.MIN_ON          (MIN_ON),
		.MAX_ON          (MAX_ON),
		.MIN_OFF         (MIN_OFF),
		.I_HIGH          (I_HIGH),
		.I_LOW           (I_LOW),
		.PULSES_PER_SHOT (PULSES_PER_SHOT)
	) dut (.*);

	initial begin
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// keypad model
	//////////////////////////////////////////////////////////////////////

	// rows in scan order 1, 6, 5, 3
	function automatic logic [2:0] row_pin(input int row);
		case (row)
			0:       return 3'd1;
			1:       return 3'd6;
			2:       return 3'd5;
			default: return 3'd3;
		endcase
	endfunction

	// columns 0, 1, 2 sit on pins 4, 0, 2
	function automatic logic [2:0] col_pin(input int col);
		case (col)
			0:       return 3'd4;
			1:       return 3'd0;
			default: return 3'd2;
		endcase
	endfunction

	// held key pulls its column low while its row is driven
	always @(negedge clk) begin
		keypad_in = 7'h7F;
		if (key_held && !keypad_out[row_pin(held_row)])
			keypad_in[col_pin(held_col)] = 1'b0;
	end

	// keys laid out row by row, column 2 first
	task automatic press_key(input blaster_pkg::key_code_e code);
		int pos;
		if (code == blaster_pkg::KEY_FIRE)
			pos = 10;
		else if (code == blaster_pkg::KEY_DUMP)
			pos = 11;
		else
			pos = int'(code) - 1;
		held_row = pos / 3;
		held_col = 2 - pos % 3;
		key_held = 1'b1;
	endtask

	task automatic release_key();
		key_held = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	// mid scale reads as zero current
	function automatic logic [11:0] sample_for_magnitude(input int magnitude);
		return 12'(magnitude) ^ 12'h7FF;
	endfunction

	function automatic int note_half_period(input int note);
		case (note)
			1:       return 'h2CCA;
			2:       return 'h27E7;
			3:       return 'h238D;
			4:       return 'h218E;
			5:       return 'h1DE5;
			6:       return 'h1AA2;
			7:       return 'h17BA;
			8:       return 'h1665;
			default: return 0;
		endcase
	endfunction

	function automatic logic out_bit(input int sel);
		case (sel)
			SEL_PWM:    return pwm;
			SEL_DUMP:   return dump;
			SEL_CHARGE: return lt3420_charge;
			default:    return speaker;
		endcase
	endfunction

	task automatic expect_equal(input string name, input int got, input int expected);
		check_count++;
		assert (got == expected) else begin
			error_count++;
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
		end
	endtask

	task automatic require(input bit ok, input string what);
		check_count++;
		assert (ok) else begin
			error_count++;
			$display("Failure at %0t ns: %s", $time, what);
		end
	endtask

	// negedges spent at level, stops once past limit
	task automatic hold_time(input int sel, input logic level, input int limit,
		output int cycles);
		cycles = 0;
		while (out_bit(sel) == level && cycles <= limit) begin
			require(speaker_n == !speaker, "speaker_n is not the complement of speaker");
			@(negedge clk);
			cycles++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic idle_after_reset();
		expect_equal("pwm", int'(pwm), 0);
		expect_equal("speaker", int'(speaker), 0);
		expect_equal("dump", int'(dump), 0);
		expect_equal("lt3420_charge", int'(lt3420_charge), 0);
		// first row of the scan driven, unused pins high
		expect_equal("keypad_out", int'(keypad_out), 'h7D);
	endtask

	task automatic key_output(input blaster_pkg::key_code_e code, input int sel,
		input string name);
		int limit;
		int cycles;
		limit = 2 * SCAN_CYCLES + 4;
		press_key(code);
		hold_time(sel, 1'b0, limit, cycles);
		require(cycles <= limit, {name, " did not rise within two scans of the press"});
		release_key();
		hold_time(sel, 1'b1, limit, cycles);
		require(cycles <= limit, {name, " did not fall within two scans of the release"});
	endtask

	task automatic led_outputs();
		for (int i = 0; i < 8; i++) begin
			fire_button = i[0];
			lt3420_done = i[1];
			cont_n      = i[2];
			@(negedge clk);
			// arm LED dark only with both inputs low
			expect_equal("arm_led_n", int'(arm_led_n), (i % 4 == 0) ? 1 : 0);
			expect_equal("cont_led_n", int'(cont_led_n), i / 4);
		end
		fire_button = 1'b0;
		lt3420_done = 1'b0;
		cont_n      = 1'b1;
	endtask

	task automatic note_pitch(input int note);
		int half;
		int limit;
		int cycles;
		int quiet;
		half  = note_half_period(note);
		limit = 2 * SCAN_CYCLES + 2 * half + 16;
		press_key(blaster_pkg::key_code_e'(4'(note)));
		hold_time(SEL_SPEAKER, 1'b0, limit, cycles);
		require(cycles <= limit, "speaker never sounded for the held note");
		hold_time(SEL_SPEAKER, 1'b1, half + 8, cycles);
		expect_equal("speaker high cycles", cycles, half + 1);
		hold_time(SEL_SPEAKER, 1'b0, half + 8, cycles);
		expect_equal("speaker low cycles", cycles, half + 1);
		release_key();
		// silent once a low run outlasts one phase
		quiet  = 0;
		cycles = 0;
		while (quiet < half + 2 && cycles <= limit) begin
			quiet = speaker ? 0 : quiet + 1;
			@(negedge clk);
			cycles++;
		end
		require(quiet >= half + 2, "speaker still sounding after the note key was released");
	endtask

	task automatic low_current_shot();
		int cycles;
		current_sample = sample_for_magnitude(0);
		fire_button    = 1'b1;
		hold_time(SEL_PWM, 1'b0, TICK_CYCLES + 4, cycles);
		require(cycles <= TICK_CYCLES + 4, "fire button did not start a shot");
		fire_button = 1'b0;
		for (int p = 0; p < PULSES_PER_SHOT; p++) begin
			hold_time(SEL_PWM, 1'b1, MAX_ON + 8, cycles);
			expect_equal("pwm high cycles", cycles, MAX_ON);
			hold_time(SEL_PWM, 1'b0, 2 * TICK_CYCLES, cycles);
			if (p < PULSES_PER_SHOT - 1)
				expect_equal("pwm low cycles", cycles, MIN_OFF + 1);
			else
				require(cycles > 2 * TICK_CYCLES, "pwm pulsed again after the last pulse");
		end
	endtask

	task automatic over_current_cutoff();
		int cycles;
		int low_time;
		current_sample = sample_for_magnitude(500);
		fire_button    = 1'b1;
		hold_time(SEL_PWM, 1'b0, TICK_CYCLES + 4, cycles);
		require(cycles <= TICK_CYCLES + 4, "fire button did not start a shot");
		fire_button = 1'b0;
		hold_time(SEL_PWM, 1'b1, MAX_ON + 8, cycles);
		expect_equal("pwm high cycles", cycles, MIN_ON);
		// current held high well past the minimum off time
		hold_time(SEL_PWM, 1'b0, MIN_OFF + 64, low_time);
		require(low_time > MIN_OFF + 64, "pwm restarted while the current was still high");
		current_sample = sample_for_magnitude(300);
		hold_time(SEL_PWM, 1'b0, 8, cycles);
		require(cycles <= 8, "pwm did not restart once the current fell");
		// second pulse cut off too, current falls early in the off phase
		current_sample = sample_for_magnitude(500);
		hold_time(SEL_PWM, 1'b1, MAX_ON + 8, cycles);
		expect_equal("pwm high cycles", cycles, MIN_ON);
		hold_time(SEL_PWM, 1'b0, MIN_OFF / 2 - 1, low_time);
		current_sample = sample_for_magnitude(300);
		hold_time(SEL_PWM, 1'b0, MIN_OFF + 8, cycles);
		expect_equal("pwm low cycles", low_time + cycles, MIN_OFF + 1);
		hold_time(SEL_PWM, 1'b1, MAX_ON + 8, cycles);
		expect_equal("pwm high cycles", cycles, MAX_ON);
		current_sample = sample_for_magnitude(0);
	endtask

	task automatic fire_key_shot();
		int limit;
		int cycles;
		limit = 2 * SCAN_CYCLES + TICK_CYCLES + 8;
		press_key(blaster_pkg::KEY_FIRE);
		hold_time(SEL_PWM, 1'b0, limit, cycles);
		require(cycles <= limit, "fire key did not start a shot");
		release_key();
		hold_time(SEL_PWM, 1'b1, MAX_ON + 8, cycles);
		expect_equal("pwm high cycles", cycles, MAX_ON);
	endtask

	initial begin
		int note_a;
		int note_b;
		void'($urandom(32'hd3f53e9c));
		reset          = 1'b1;
		fire_button    = 1'b0;
		lt3420_done    = 1'b0;
		cont_n         = 1'b1;
		current_sample = sample_for_magnitude(0);
		repeat (3) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		idle_after_reset();
		key_output(blaster_pkg::KEY_DUMP, SEL_DUMP, "dump");
		key_output(blaster_pkg::KEY_CHARGE, SEL_CHARGE, "lt3420_charge");
		led_outputs();
		// two different notes
		note_a = 1 + int'($urandom % 8);
		note_b = 1 + (note_a + int'($urandom % 7)) % 8;
		note_pitch(note_a);
		note_pitch(note_b);
		low_current_shot();
		over_current_cutoff();
		fire_key_shot();
		$display("Summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== source/blaster_top.sv ====
`timescale 1ns/10ps

module blaster_top #(
	parameter int SCAN_BITS       = 12,
	parameter int TRIGGER_BITS    = 16,
	parameter int MIN_ON          = 48,
	parameter int MAX_ON          = 768,
	parameter int MIN_OFF         = 144,
	parameter int I_HIGH          = 430,
	parameter int I_LOW           = 390,
	parameter int PULSES_PER_SHOT = 3
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                fire_button,
	input  logic                                lt3420_done,
	input  logic                                cont_n,
	input  logic [blaster_pkg::SAMPLE_WIDTH-1:0] current_sample,
	input  logic [6:0]                          keypad_in,
	output logic [6:0]                          keypad_out,
	output logic                                speaker,
	output logic                                speaker_n,
	output logic                                pwm,
	output logic                                dump,
	output logic                                lt3420_charge,
	output logic                                arm_led_n,
	output logic                                cont_led_n
);

	blaster_pkg::key_t key;
	logic [6:0]        row_drive;

	// column pads idle high, rows come from the scanner
	assign keypad_out = row_drive | 7'b0010101;

	//////////////////////////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////////////////////////

	key_scan #(
		.SCAN_BITS (SCAN_BITS)
	) u_key_scan (
		.clk        (clk),
		.reset      (reset),
		.keypad_in  (keypad_in),
		.keypad_out (row_drive),
		.key        (key)
	);

	tone_gen u_tone_gen (
		.clk       (clk),
		.reset     (reset),
		.key       (key),
		.speaker   (speaker),
		.speaker_n (speaker_n)
	);

	hv_control #(
		.TRIGGER_BITS    (TRIGGER_BITS),
		.MIN_ON          (MIN_ON),
		.MAX_ON          (MAX_ON),
		.MIN_OFF         (MIN_OFF),
		.I_HIGH          (I_HIGH),
		.I_LOW           (I_LOW),
		.PULSES_PER_SHOT (PULSES_PER_SHOT)
	) u_hv_control (
		.clk            (clk),
		.reset          (reset),
		.key            (key),
		.fire_button    (fire_button),
		.lt3420_done    (lt3420_done),
		.cont_n         (cont_n),
		.current_sample (current_sample),
		.pwm            (pwm),
		.dump           (dump),
		.lt3420_charge  (lt3420_charge),
		.arm_led_n      (arm_led_n),
		.cont_led_n     (cont_led_n)
	);

endmodule

// ==== source/hv_control.sv ====
`timescale 1ns/10ps

module hv_control #(
	parameter int TRIGGER_BITS    = 16,
	parameter int MIN_ON          = 48,
	parameter int MAX_ON          = 768,
	parameter int MIN_OFF         = 144,
	parameter int I_HIGH          = 430,
	parameter int I_LOW           = 390,
	parameter int PULSES_PER_SHOT = 3
) (
	input  logic                                clk,
	input  logic                                reset,
	input  blaster_pkg::key_t                   key,
	input  logic                                fire_button,
	input  logic                                lt3420_done,
	input  logic                                cont_n,
	input  logic [blaster_pkg::SAMPLE_WIDTH-1:0] current_sample,
	output logic                                pwm,
	output logic                                dump,
	output logic                                lt3420_charge,
	output logic                                arm_led_n,
	output logic                                cont_led_n
);

	localparam int LONGEST   = (MAX_ON > MIN_OFF) ? MAX_ON : MIN_OFF;
	localparam int TIME_BITS = $clog2(LONGEST + 1);
	localparam int CNT_BITS  = $clog2(PULSES_PER_SHOT + 1);

	logic [TRIGGER_BITS-1:0]              trig_cnt;
	logic                                 tick;
	logic                                 fire;
	logic [blaster_pkg::SAMPLE_WIDTH-1:0] magnitude;
	logic                                 over_current;
	logic                                 current_low;
	blaster_pkg::pulse_state_e            state;
	logic [TIME_BITS-1:0]                 pulse_time;
	logic [CNT_BITS-1:0]                  pulses_left;

	// retrigger window, about 1.3 ms at 48 MHz with 16 bits
	always_ff @(posedge clk) begin
		if (reset)
			trig_cnt <= '0;
		else
			trig_cnt <= trig_cnt + 1'b1;
	end

	assign tick = (trig_cnt == '0);
	assign fire = fire_button || (key.pressed && key.code == blaster_pkg::KEY_FIRE);

	// a set top bit reads as negative or zero current
	assign magnitude    = blaster_pkg::current_magnitude(current_sample);
	assign over_current = !current_sample[blaster_pkg::SAMPLE_WIDTH-1] && (magnitude > I_HIGH);
	assign current_low  = current_sample[blaster_pkg::SAMPLE_WIDTH-1] || (magnitude < I_LOW);

	//////////////////////////////////////////////////////////////////////
	// current limited pulse FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= blaster_pkg::PULSE_IDLE;
			pulse_time  <= '0;
			pulses_left <= '0;
		end else begin
			case (state)
				blaster_pkg::PULSE_ON: begin
					if (pulse_time < MIN_ON) begin
						pulse_time <= pulse_time + 1'b1;
					end else if (pulse_time >= MAX_ON || over_current) begin
						pulse_time  <= '0;
						pulses_left <= pulses_left - 1'b1;
						if (pulses_left == CNT_BITS'(1))
							state <= blaster_pkg::PULSE_IDLE;
						else
							state <= blaster_pkg::PULSE_OFF;
					end else begin
						pulse_time <= pulse_time + 1'b1;
					end
				end
				blaster_pkg::PULSE_OFF: begin
					// hold off until the coil current has decayed
					if (pulse_time >= MIN_OFF && current_low) begin
						state      <= blaster_pkg::PULSE_ON;
						pulse_time <= TIME_BITS'(1);
					end else if (pulse_time < MIN_OFF) begin
						pulse_time <= pulse_time + 1'b1;
					end
				end
				default: begin
					pulse_time <= '0;
					if (tick && fire) begin
						state       <= blaster_pkg::PULSE_ON;
						pulse_time  <= TIME_BITS'(1);
						pulses_left <= CNT_BITS'(PULSES_PER_SHOT);
					end
				end
			endcase
		end
	end

	assign pwm = (state == blaster_pkg::PULSE_ON);

	// direct high voltage controls
	assign dump          = key.pressed && key.code == blaster_pkg::KEY_DUMP;
	assign lt3420_charge = key.pressed && key.code == blaster_pkg::KEY_CHARGE;
	assign arm_led_n     = !(fire_button || lt3420_done);
	// LED lit while continuity is present
	assign cont_led_n    = cont_n;

endmodule

// ==== source/tone_gen.sv ====
`timescale 1ns/10ps

module tone_gen (
	input  logic              clk,
	input  logic              reset,
	input  blaster_pkg::key_t key,
	output logic              speaker,
	output logic              speaker_n
);

	logic [15:0] tone_cnt;
	logic [15:0] half;
	logic        spk_en;
	logic        spk_toggle;

	// pitch of the held note, silent when nothing is down
	always_comb begin
		if (key.pressed)
			half = blaster_pkg::tone_half_period(key.code);
		else
			half = 16'h0000;
	end

	//////////////////////////////////////////////////////////////////////
	// half period counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			tone_cnt   <= '0;
			spk_en     <= 1'b0;
			spk_toggle <= 1'b0;
		end else if (tone_cnt == 16'h0000) begin
			// each phase is half plus one cycles
			spk_toggle <= !spk_toggle;
			tone_cnt   <= half;
			spk_en     <= (half != 16'h0000);
		end else begin
			tone_cnt <= tone_cnt - 1'b1;
		end
	end

	// differential drive doubles the swing
	assign speaker   = spk_toggle & spk_en;
	assign speaker_n = !speaker;

endmodule

// ==== source/key_scan.sv ====
`timescale 1ns/10ps

module key_scan #(
	parameter int SCAN_BITS = 12
) (
	input  logic               clk,
	input  logic               reset,
	input  logic [6:0]         keypad_in,
	output logic [6:0]         keypad_out,
	output blaster_pkg::key_t  key
);

	// sample point 16 cycles before the end of each row's quarter
	localparam logic [SCAN_BITS-3:0] LATCH_AT = {(SCAN_BITS-2){1'b1}} - 15;

	logic [SCAN_BITS-1:0] div;
	logic [1:0]           quarter;
	logic [2:0]           cols_n;
	logic [2:0]           col;
	logic [1:0]           row;
	logic                 flag;
	logic [1:0]           col_sel;
	logic [3:0]           code_val;
	blaster_pkg::key_t    key_next;

	assign quarter = div[SCAN_BITS-1 -: 2];

	// column 2, 1, 0
	assign cols_n = {keypad_in[2], keypad_in[0], keypad_in[4]};

	//////////////////////////////////////////////////////////////////////
	// row drive and capture
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			div        <= '0;
			col        <= '0;
			row        <= '0;
			flag       <= 1'b0;
			keypad_out <= 7'b1101010;
		end else begin
			div <= div + 1'b1;

			// rows active low in scan order 1, 6, 5, 3
			keypad_out    <= '0;
			keypad_out[1] <= (quarter != 2'd0);
			keypad_out[6] <= (quarter != 2'd1);
			keypad_out[5] <= (quarter != 2'd2);
			keypad_out[3] <= (quarter != 2'd3);

			if (div == '0) begin
				flag <= 1'b0;
			end else if (div == '1 && !flag) begin
				// full scan with nothing down
				col <= '0;
			end else if (div[SCAN_BITS-3:0] == LATCH_AT && cols_n != 3'b111) begin
				flag <= 1'b1;
				col  <= ~cols_n;
				row  <= quarter;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// encode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// column 0 wins when several are down
		if (col[0])
			col_sel = 2'd0;
		else if (col[1])
			col_sel = 2'd1;
		else
			col_sel = 2'd2;

		// rows 0 to 2 hold the notes and the spare, 1 to 9
		code_val = {2'b00, row} * 4'd3 + 4'd3 - {2'b00, col_sel};

		key_next.pressed = (col != 3'b000);
		if (row == 2'd3) begin
			case (col_sel)
				2'd2:    key_next.code = blaster_pkg::KEY_CHARGE;
				2'd1:    key_next.code = blaster_pkg::KEY_FIRE;
				default: key_next.code = blaster_pkg::KEY_DUMP;
			endcase
		end else begin
			key_next.code = blaster_pkg::key_code_e'(code_val);
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			key <= '0;
		else
			key <= key_next;
	end

endmodule

// ==== source/blaster_pkg.sv ====
package blaster_pkg;

	//////////////////////////////////////////////////////////////////////
	// keypad
	//////////////////////////////////////////////////////////////////////

	// keypad codes, notes hold their pitch index
	typedef enum logic [3:0] {
		KEY_FIRE   = 4'd0,
		KEY_NOTE_1 = 4'd1,
		KEY_NOTE_2 = 4'd2,
		KEY_NOTE_3 = 4'd3,
		KEY_NOTE_4 = 4'd4,
		KEY_NOTE_5 = 4'd5,
		KEY_NOTE_6 = 4'd6,
		KEY_NOTE_7 = 4'd7,
		KEY_NOTE_8 = 4'd8,
		KEY_SPARE  = 4'd9,
		KEY_CHARGE = 4'd10,
		KEY_DUMP   = 4'd11
	} key_code_e;

	// one key at a time, code only valid while pressed
	typedef struct packed {
		logic      pressed;
		key_code_e code;
	} key_t;

	//////////////////////////////////////////////////////////////////////
	// pulse generator
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		PULSE_IDLE = 2'd0,
		PULSE_ON   = 2'd1,
		PULSE_OFF  = 2'd2
	} pulse_state_e;

	// held output current sample
	parameter int SAMPLE_WIDTH = 12;

	// half period in 48 MHz cycles, 0 is silence
	function automatic logic [15:0] tone_half_period(input key_code_e code);
		logic [15:0] half;
		case (code)
			KEY_NOTE_1: half = 16'h2CCA;
			KEY_NOTE_2: half = 16'h27E7;
			KEY_NOTE_3: half = 16'h238D;
			KEY_NOTE_4: half = 16'h218E;
			KEY_NOTE_5: half = 16'h1DE5;
			KEY_NOTE_6: half = 16'h1AA2;
			KEY_NOTE_7: half = 16'h17BA;
			KEY_NOTE_8: half = 16'h1665;
			default:    half = 16'h0000;
		endcase
		return half;
	endfunction

	// converter reads offset from mid scale
	// only meaningful while the top bit is clear
	function automatic logic [SAMPLE_WIDTH-1:0] current_magnitude(
		input logic [SAMPLE_WIDTH-1:0] sample
	);
		return sample ^ 12'h7FF;
	endfunction

endpackage
